/* include/wresp_bank_cfg.svh */
`ifndef WRESP_BANK_CFG_SVH
`define WRESP_BANK_CFG_SVH

// Message word and its ID field
`define WRB_MSG_W 32
`define WRB_ID_W 2
`define WRB_NUM_IDS 4

// Slot pool
`define WRB_CAPACITY 16
`define WRB_ADDR_W 4
`define WRB_CNT_W 5

`endif

/* design/wresp_bank_pkg.sv */
`include "wresp_bank_cfg.svh"

package wresp_bank_pkg;

  // Field view of a message word, ID in the low bits
  typedef struct packed {
    logic [`WRB_MSG_W-`WRB_ID_W-1:0] payload;
    logic [`WRB_ID_W-1:0]            id;
  } wresp_msg_fields_t;

  // Storage handles the raw word, the controller reads the fields
  typedef union packed {
    logic [`WRB_MSG_W-1:0] raw;
    wresp_msg_fields_t     fields;
  } wresp_msg_u;

  // One message write and one link write per cycle
  typedef struct packed {
    logic                   msg_en;
    logic [`WRB_ADDR_W-1:0] msg_addr;
    wresp_msg_u             msg;
    logic                   link_en;
    logic [`WRB_ADDR_W-1:0] link_addr;
    logic [`WRB_ADDR_W-1:0] link_data;
  } wresp_store_wr_t;

  // What the release side needs to know about one ID
  typedef struct packed {
    logic [`WRB_ADDR_W-1:0] tail;
    logic                   filled;
  } wresp_id_view_t;

  typedef wresp_id_view_t [`WRB_NUM_IDS-1:0] wresp_id_view_a;

  // Grant issued when the output register loads
  typedef struct packed {
    logic                   valid;
    logic [`WRB_ID_W-1:0]   id;
    logic [`WRB_ADDR_W-1:0] addr;
  } wresp_grant_t;

endpackage

/* design/wresp_slot_alloc.sv */
`timescale 1ns/100ps
`include "wresp_bank_cfg.svh"

module wresp_slot_alloc (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     reserve_i,
  input  logic [`WRB_CAPACITY-1:0] release_onehot_i,
  output logic [`WRB_ADDR_W-1:0]   free_addr_o,
  output logic                     any_free_o
);

  // One bit per slot, set while the slot belongs to a list or the output
  logic [`WRB_CAPACITY-1:0] occ_q;
  logic [`WRB_CAPACITY-1:0] occ_d;

  // Lowest free slot wins
  always_comb begin
    free_addr_o = '0;
    for (int s = `WRB_CAPACITY - 1; s >= 0; s--) begin
      if (!occ_q[s]) begin
        free_addr_o = `WRB_ADDR_W'(s);
      end
    end
  end

  assign any_free_o = ~&occ_q;

  always_comb begin
    occ_d = occ_q & ~release_onehot_i;
    if (reserve_i) begin
      occ_d[free_addr_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

endmodule

/* design/wresp_slot_store.sv */
`timescale 1ns/100ps
`include "wresp_bank_cfg.svh"

module wresp_slot_store (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  wresp_bank_pkg::wresp_store_wr_t wr_i,
  input  logic [`WRB_ADDR_W-1:0]          middle_addr_i,
  input  logic [`WRB_ADDR_W-1:0]          tail_addr_i,
  input  logic [`WRB_ADDR_W-1:0]          msg_rd_addr_i,
  output logic [`WRB_ADDR_W-1:0]          middle_link_o,
  output logic [`WRB_ADDR_W-1:0]          tail_link_o,
  output wresp_bank_pkg::wresp_msg_u      msg_rd_o
);

  // Message words, kept as raw data
  logic [`WRB_MSG_W-1:0] msg_mem [`WRB_CAPACITY];

  // Next newer slot of the same ID
  logic [`WRB_ADDR_W-1:0] link_mem [`WRB_CAPACITY];

  ////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_i.msg_en) begin
      msg_mem[wr_i.msg_addr] <= wr_i.msg.raw;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < `WRB_CAPACITY; s++) begin
        link_mem[s] <= '0;
      end
    end else if (wr_i.link_en) begin
      link_mem[wr_i.link_addr] <= wr_i.link_data;
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  assign middle_link_o = link_mem[middle_addr_i];
  assign tail_link_o = link_mem[tail_addr_i];
  assign msg_rd_o.raw = msg_mem[msg_rd_addr_i];

endmodule

/* design/wresp_release_sel.sv */
`timescale 1ns/100ps
`include "wresp_bank_cfg.svh"

module wresp_release_sel (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  wresp_bank_pkg::wresp_id_view_a id_view_i,
  input  logic [`WRB_CAPACITY-1:0]       release_en_i,
  input  wresp_bank_pkg::wresp_msg_u     msg_rd_i,
  input  logic                           out_ready_i,
  output wresp_bank_pkg::wresp_grant_t   grant_o,
  output logic [`WRB_ADDR_W-1:0]         msg_rd_addr_o,
  output wresp_bank_pkg::wresp_msg_u     data_o,
  output logic                           out_valid_o,
  output logic [`WRB_CAPACITY-1:0]       address_released_onehot_o
);

  logic [`WRB_NUM_IDS-1:0] eligible;
  logic                    accept;
  logic                    load;
  logic                    valid_q;
  logic [`WRB_ADDR_W-1:0]  addr_q;
  wresp_bank_pkg::wresp_msg_u data_q;

  // ID is eligible when its oldest filled slot has its release enable
  for (genvar g = 0; g < `WRB_NUM_IDS; g++) begin : gen_elig
    assign eligible[g] = id_view_i[g].filled && release_en_i[id_view_i[g].tail];
  end

  assign accept = valid_q && out_ready_i;
  assign load = (!valid_q || out_ready_i) && (|eligible);

  // Lowest eligible ID
  always_comb begin
    grant_o = '0;
    for (int i = `WRB_NUM_IDS - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        grant_o.id = `WRB_ID_W'(i);
        grant_o.addr = id_view_i[i].tail;
      end
    end
    grant_o.valid = load;
  end

  assign msg_rd_addr_o = grant_o.addr;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (accept) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= msg_rd_i;
      addr_q <= grant_o.addr;
    end
  end

  assign out_valid_o = valid_q;
  assign data_o = data_q;
  assign address_released_onehot_o = accept ? (`WRB_CAPACITY'(1) << addr_q) : '0;

endmodule

/* design/wresp_queue_ctrl.sv */
`timescale 1ns/100ps
`include "wresp_bank_cfg.svh"

module wresp_queue_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [`WRB_NUM_IDS-1:0]         reservation_id_onehot_i,
  input  logic                            reservation_ready_i,
  input  wresp_bank_pkg::wresp_msg_u      data_i,
  input  logic                            in_valid_i,
  input  logic [`WRB_ADDR_W-1:0]          free_addr_i,
  input  logic                            any_free_i,
  input  logic [`WRB_ADDR_W-1:0]          middle_link_i,
  input  logic [`WRB_ADDR_W-1:0]          tail_link_i,
  input  wresp_bank_pkg::wresp_grant_t    grant_i,
  output logic                            in_ready_o,
  output logic                            reservation_valid_o,
  output logic                            reserve_o,
  output wresp_bank_pkg::wresp_store_wr_t store_wr_o,
  output logic [`WRB_ADDR_W-1:0]          middle_addr_o,
  output logic [`WRB_ADDR_W-1:0]          tail_addr_o,
  output wresp_bank_pkg::wresp_id_view_a  id_view_o
);

  // List order per ID is tail, filled slots, middle, reserved slots, head
  logic [`WRB_ADDR_W-1:0] head_q   [`WRB_NUM_IDS];
  logic [`WRB_ADDR_W-1:0] head_d   [`WRB_NUM_IDS];
  logic [`WRB_ADDR_W-1:0] middle_q [`WRB_NUM_IDS];
  logic [`WRB_ADDR_W-1:0] middle_d [`WRB_NUM_IDS];
  logic [`WRB_ADDR_W-1:0] tail_q   [`WRB_NUM_IDS];
  logic [`WRB_ADDR_W-1:0] tail_d   [`WRB_NUM_IDS];
  logic [`WRB_CNT_W-1:0]  resv_q   [`WRB_NUM_IDS];
  logic [`WRB_CNT_W-1:0]  resv_d   [`WRB_NUM_IDS];
  logic [`WRB_CNT_W-1:0]  fill_q   [`WRB_NUM_IDS];
  logic [`WRB_CNT_W-1:0]  fill_d   [`WRB_NUM_IDS];

  logic [`WRB_ID_W-1:0] in_id;
  logic                 fill;

  // A link written this cycle is seen by a pointer walking through it
  function automatic logic [`WRB_ADDR_W-1:0] link_fwd(
    input wresp_bank_pkg::wresp_store_wr_t wr,
    input logic [`WRB_ADDR_W-1:0]          addr,
    input logic [`WRB_ADDR_W-1:0]          link
  );
    return (wr.link_en && wr.link_addr == addr) ? wr.link_data : link;
  endfunction

  assign in_id = data_i.fields.id;
  assign in_ready_o = in_valid_i && (resv_q[in_id] != '0);
  assign fill = in_ready_o;

  assign reservation_valid_o = any_free_i;
  assign reserve_o = any_free_i && reservation_ready_i && (|reservation_id_onehot_i);

  assign middle_addr_o = middle_q[in_id];
  assign tail_addr_o = tail_q[grant_i.id];

  ////////////////////////////////////////
  // Store writes
  ////////////////////////////////////////

  always_comb begin
    store_wr_o = '0;
    store_wr_o.msg_en = fill;
    store_wr_o.msg_addr = middle_q[in_id];
    store_wr_o.msg = data_i;
    // New slot hangs off the old head when the list already exists
    for (int i = 0; i < `WRB_NUM_IDS; i++) begin
      if (reserve_o && reservation_id_onehot_i[i] &&
          (resv_q[i] != '0 || fill_q[i] != '0)) begin
        store_wr_o.link_en = 1'b1;
        store_wr_o.link_addr = head_q[i];
        store_wr_o.link_data = free_addr_i;
      end
    end
  end

  ////////////////////////////////////////
  // Pointer and counter updates
  ////////////////////////////////////////

  always_comb begin
    logic res_hit;
    logic fill_hit;
    logic grant_hit;
    logic empty;
    for (int i = 0; i < `WRB_NUM_IDS; i++) begin
      res_hit = reserve_o && reservation_id_onehot_i[i];
      fill_hit = fill && (in_id == `WRB_ID_W'(i));
      grant_hit = grant_i.valid && (grant_i.id == `WRB_ID_W'(i));
      empty = (resv_q[i] == '0) && (fill_q[i] == '0);

      head_d[i] = res_hit ? free_addr_i : head_q[i];

      // Middle follows a fresh reservation, or steps along the list on a fill
      if (res_hit && resv_q[i] == '0) begin
        middle_d[i] = free_addr_i;
      end else if (fill_hit) begin
        middle_d[i] = link_fwd(store_wr_o, middle_q[i], middle_link_i);
      end else begin
        middle_d[i] = middle_q[i];
      end

      if (res_hit && empty) begin
        tail_d[i] = free_addr_i;
      end else if (grant_hit) begin
        tail_d[i] = link_fwd(store_wr_o, tail_q[i], tail_link_i);
      end else begin
        tail_d[i] = tail_q[i];
      end

      resv_d[i] = resv_q[i];
      if (res_hit) begin
        resv_d[i] = resv_d[i] + `WRB_CNT_W'(1);
      end
      if (fill_hit) begin
        resv_d[i] = resv_d[i] - `WRB_CNT_W'(1);
      end

      fill_d[i] = fill_q[i];
      if (fill_hit) begin
        fill_d[i] = fill_d[i] + `WRB_CNT_W'(1);
      end
      if (grant_hit) begin
        fill_d[i] = fill_d[i] - `WRB_CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `WRB_NUM_IDS; i++) begin
        head_q[i] <= '0;
        middle_q[i] <= '0;
        tail_q[i] <= '0;
        resv_q[i] <= '0;
        fill_q[i] <= '0;
      end
    end else begin
      head_q <= head_d;
      middle_q <= middle_d;
      tail_q <= tail_d;
      resv_q <= resv_d;
      fill_q <= fill_d;
    end
  end

  // Release view
  for (genvar g = 0; g < `WRB_NUM_IDS; g++) begin : gen_view
    assign id_view_o[g].tail = tail_q[g];
    assign id_view_o[g].filled = (fill_q[g] != '0);
  end

endmodule

/* design/wresp_bank_top.sv */
`timescale 1ns/100ps
`include "wresp_bank_cfg.svh"

module wresp_bank_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Reservation
  input  logic [`WRB_NUM_IDS-1:0]       reservation_id_onehot_i,
  input  logic                          reservation_ready_i,
  output logic                          reservation_valid_o,
  output logic [`WRB_ADDR_W-1:0]        new_reserved_address_o,

  // Input messages
  input  wresp_bank_pkg::wresp_msg_u    data_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,

  // Release and output
  input  logic [`WRB_CAPACITY-1:0]      release_en_i,
  output wresp_bank_pkg::wresp_msg_u    data_o,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic [`WRB_CAPACITY-1:0]      address_released_onehot_o
);

  logic                            any_free;
  logic                            reserve;
  wresp_bank_pkg::wresp_store_wr_t store_wr;
  logic [`WRB_ADDR_W-1:0]          middle_addr;
  logic [`WRB_ADDR_W-1:0]          tail_addr;
  logic [`WRB_ADDR_W-1:0]          middle_link;
  logic [`WRB_ADDR_W-1:0]          tail_link;
  logic [`WRB_ADDR_W-1:0]          msg_rd_addr;
  wresp_bank_pkg::wresp_msg_u      msg_rd;
  wresp_bank_pkg::wresp_id_view_a  id_view;
  wresp_bank_pkg::wresp_grant_t    grant;

  wresp_queue_ctrl u_queue_ctrl (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .reservation_id_onehot_i (reservation_id_onehot_i),
    .reservation_ready_i     (reservation_ready_i),
    .data_i                  (data_i),
    .in_valid_i              (in_valid_i),
    .free_addr_i             (new_reserved_address_o),
    .any_free_i              (any_free),
    .middle_link_i           (middle_link),
    .tail_link_i             (tail_link),
    .grant_i                 (grant),
    .in_ready_o              (in_ready_o),
    .reservation_valid_o     (reservation_valid_o),
    .reserve_o               (reserve),
    .store_wr_o              (store_wr),
    .middle_addr_o           (middle_addr),
    .tail_addr_o             (tail_addr),
    .id_view_o               (id_view)
  );

  // Freed slots go back to the allocator as they leave the output
  wresp_slot_alloc u_slot_alloc (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .reserve_i        (reserve),
    .release_onehot_i (address_released_onehot_o),
    .free_addr_o      (new_reserved_address_o),
    .any_free_o       (any_free)
  );

  wresp_slot_store u_slot_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wr_i          (store_wr),
    .middle_addr_i (middle_addr),
    .tail_addr_i   (tail_addr),
    .msg_rd_addr_i (msg_rd_addr),
    .middle_link_o (middle_link),
    .tail_link_o   (tail_link),
    .msg_rd_o      (msg_rd)
  );

  wresp_release_sel u_release_sel (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .id_view_i                 (id_view),
    .release_en_i              (release_en_i),
    .msg_rd_i                  (msg_rd),
    .out_ready_i               (out_ready_i),
    .grant_o                   (grant),
    .msg_rd_addr_o             (msg_rd_addr),
    .data_o                    (data_o),
    .out_valid_o               (out_valid_o),
    .address_released_onehot_o (address_released_onehot_o)
  );

endmodule

/* testbench/wresp_clk_gen.sv */
`timescale 1ns/100ps

module wresp_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held over the first four rising edges
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* testbench/wresp_bank_chk.sv */
`timescale 1ns/100ps
`include "wresp_bank_cfg.svh"

module wresp_bank_chk (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     out_valid_i,
  input  logic                     out_ready_i,
  input  logic [`WRB_MSG_W-1:0]    out_data_i,
  input  logic [`WRB_MSG_W-1:0]    in_data_i,
  input  logic                     in_valid_i,
  input  logic                     in_ready_i,
  input  logic [`WRB_NUM_IDS-1:0]  resv_onehot_i,
  input  logic                     resv_ready_i,
  input  logic                     reservation_valid_i,
  input  logic [`WRB_ADDR_W-1:0]   resv_addr_i,
  input  logic [`WRB_CAPACITY-1:0] released_i
);

  // Slot occupancy and open reservations per ID, rebuilt from the ports
  logic [`WRB_CAPACITY-1:0] occ_m;
  logic [`WRB_CNT_W-1:0]    pend_m [`WRB_NUM_IDS];
  logic [`WRB_ID_W-1:0]     in_id;
  logic                     resv_fire;
  logic                     fill_fire;
  logic                     in_pend;

  assign in_id = in_data_i[`WRB_ID_W-1:0];
  assign resv_fire = reservation_valid_i && resv_ready_i && (|resv_onehot_i);
  assign fill_fire = in_valid_i && in_ready_i;
  assign in_pend = (pend_m[in_id] != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_m <= '0;
      for (int i = 0; i < `WRB_NUM_IDS; i++) begin
        pend_m[i] <= '0;
      end
    end else begin
      occ_m <= (occ_m & ~released_i) |
               (resv_fire ? (`WRB_CAPACITY'(1) << resv_addr_i) : '0);
      for (int i = 0; i < `WRB_NUM_IDS; i++) begin
        pend_m[i] <= pend_m[i] + `WRB_CNT_W'(resv_fire && resv_onehot_i[i])
                     - `WRB_CNT_W'(fill_fire && (in_id == `WRB_ID_W'(i)));
      end
    end
  end

  // Output register holds while stalled
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_data_i)))
    else $error("out_valid_o or data_o changed under back-pressure");

  // Only one slot leaves at a time, and it must be one that was reserved
  a_release_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(released_i) && ((released_i & ~occ_m) == '0))
    else $error("address_released_onehot_o is not a single occupied slot");

  a_in_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_ready_i == (in_valid_i && in_pend))
    else $error("in_ready_o disagrees with in_valid_i and the open reservations");

  // No reservation offered only when the pool is full
  a_resv_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !reservation_valid_i |-> (&occ_m))
    else $error("reservation_valid_o low while a slot is free");

endmodule

bind wresp_bank_top wresp_bank_chk u_chk (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .out_valid_i         (out_valid_o),
  .out_ready_i         (out_ready_i),
  .out_data_i          (data_o),
  .in_data_i           (data_i),
  .in_valid_i          (in_valid_i),
  .in_ready_i          (in_ready_o),
  .resv_onehot_i       (reservation_id_onehot_i),
  .resv_ready_i        (reservation_ready_i),
  .reservation_valid_i (reservation_valid_o),
  .resv_addr_i         (new_reserved_address_o),
  .released_i          (address_released_onehot_o)
);

/* testbench/wresp_bank_tb.sv */
`timescale 1ns/100ps
`include "wresp_bank_cfg.svh"

module wresp_bank_tb;

  localparam int NUM_CYCLES = 400;
  localparam int TIMEOUT_CYCLES = (NUM_CYCLES + `WRB_CAPACITY) * 40;

  logic                       clk;
  logic                       rst_n;
  logic [`WRB_NUM_IDS-1:0]    reservation_id_onehot_i;
  logic                       reservation_ready_i;
  logic                       reservation_valid_o;
  logic [`WRB_ADDR_W-1:0]     new_reserved_address_o;
  wresp_bank_pkg::wresp_msg_u data_i;
  logic                       in_valid_i;
  logic                       in_ready_o;
  logic [`WRB_CAPACITY-1:0]   release_en_i;
  wresp_bank_pkg::wresp_msg_u data_o;
  logic                       out_valid_o;
  logic                       out_ready_i;
  logic [`WRB_CAPACITY-1:0]   address_released_onehot_o;

  // Reference model
  logic [`WRB_CAPACITY-1:0]   free_m;
  logic [`WRB_ADDR_W-1:0]     resv_addr_q [`WRB_NUM_IDS][$];
  wresp_bank_pkg::wresp_msg_u fill_msg_q [`WRB_NUM_IDS][$];
  int                         stall_left;
  int                         accepts_done;

  wresp_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  wresp_bank_top UUT (
    .clk_i                     (clk),
    .rst_ni                    (rst_n),
    .reservation_id_onehot_i   (reservation_id_onehot_i),
    .reservation_ready_i       (reservation_ready_i),
    .reservation_valid_o       (reservation_valid_o),
    .new_reserved_address_o    (new_reserved_address_o),
    .data_i                    (data_i),
    .in_valid_i                (in_valid_i),
    .in_ready_o                (in_ready_o),
    .release_en_i              (release_en_i),
    .data_o                    (data_o),
    .out_valid_o               (out_valid_o),
    .out_ready_i               (out_ready_i),
    .address_released_onehot_o (address_released_onehot_o)
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input logic [`WRB_ADDR_W-1:0] got,
                            input logic [`WRB_ADDR_W-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_msg(input string name, input wresp_bank_pkg::wresp_msg_u got,
                           input wresp_bank_pkg::wresp_msg_u exp);
    if (got.raw !== exp.raw) begin
      stop_on_error($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h",
                              name, got.raw, exp.raw));
    end
  endtask

  task automatic check_slots(input string name, input logic [`WRB_CAPACITY-1:0] got,
                             input logic [`WRB_CAPACITY-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH %s: got 0x%04h expected 0x%04h", name, got, exp));
    end
  endtask

  function automatic logic [`WRB_ADDR_W-1:0] lowest_free(input logic [`WRB_CAPACITY-1:0] free);
    for (int s = 0; s < `WRB_CAPACITY; s++) begin
      if (free[s]) begin
        return `WRB_ADDR_W'(s);
      end
    end
    return '0;
  endfunction

  function automatic logic [`WRB_ID_W-1:0] onehot_to_id(input logic [`WRB_NUM_IDS-1:0] onehot);
    for (int i = 0; i < `WRB_NUM_IDS; i++) begin
      if (onehot[i]) begin
        return `WRB_ID_W'(i);
      end
    end
    return '0;
  endfunction

  function automatic logic model_empty();
    for (int i = 0; i < `WRB_NUM_IDS; i++) begin
      if (resv_addr_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  ////////////////////////////////////////
  // Stimulus, applied on the rising edge
  ////////////////////////////////////////

  task automatic drive_inputs(input logic drain);
    int                         cand [$];
    wresp_bank_pkg::wresp_msg_u msg;
    for (int i = 0; i < `WRB_NUM_IDS; i++) begin
      if (resv_addr_q[i].size() > fill_msg_q[i].size()) begin
        cand.push_back(i);
      end
    end
    reservation_ready_i <= !drain && ($urandom_range(1) == 1);
    reservation_id_onehot_i <= `WRB_NUM_IDS'(1) << $urandom_range(`WRB_NUM_IDS - 1);

    // Mostly aim at an ID that still waits for a message
    msg.raw = $urandom;
    if (cand.size() > 0 && (drain || $urandom_range(7) != 0)) begin
      msg.fields.id = `WRB_ID_W'(cand[$urandom_range(cand.size() - 1)]);
    end
    data_i <= msg;
    in_valid_i <= drain ? (cand.size() > 0) : ($urandom_range(9) < 6);

    release_en_i <= drain ? '1 : `WRB_CAPACITY'($urandom);

    // Back-pressure comes in runs of a few cycles
    if (drain) begin
      out_ready_i <= 1'b1;
    end else if (stall_left > 0) begin
      out_ready_i <= 1'b0;
      stall_left--;
    end else if ($urandom_range(7) == 0) begin
      out_ready_i <= 1'b0;
      stall_left = 2 + int'($urandom_range(4));
    end else begin
      out_ready_i <= 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // Checks at the falling edge
  ////////////////////////////////////////

  task automatic compare_and_update();
    logic [`WRB_ID_W-1:0]     in_id;
    logic [`WRB_ID_W-1:0]     out_id;
    logic [`WRB_ADDR_W-1:0]   addr;
    logic                     exp_ready;
    logic                     accept;
    logic [`WRB_CAPACITY-1:0] exp_rel;
    check_bit("reservation_valid_o", reservation_valid_o, |free_m);
    if (reservation_valid_o) begin
      check_addr("new_reserved_address_o", new_reserved_address_o, lowest_free(free_m));
    end

    in_id = data_i.fields.id;
    exp_ready = in_valid_i && (resv_addr_q[in_id].size() > fill_msg_q[in_id].size());
    check_bit("in_ready_o", in_ready_o, exp_ready);

    exp_rel = '0;
    out_id = data_o.fields.id;
    accept = out_valid_o && out_ready_i;
    if (accept) begin
      if (fill_msg_q[out_id].size() == 0) begin
        stop_on_error("Output accepted for an ID that has no filled message");
      end else begin
        check_msg("data_o", data_o, fill_msg_q[out_id][0]);
        exp_rel = `WRB_CAPACITY'(1) << resv_addr_q[out_id][0];
      end
    end
    check_slots("address_released_onehot_o", address_released_onehot_o, exp_rel);

    // Fill, then reservation, then release
    if (exp_ready) begin
      fill_msg_q[in_id].push_back(data_i);
    end
    if ((|free_m) && reservation_ready_i && (|reservation_id_onehot_i)) begin
      addr = lowest_free(free_m);
      free_m[addr] = 1'b0;
      resv_addr_q[onehot_to_id(reservation_id_onehot_i)].push_back(addr);
    end
    if (accept) begin
      free_m[resv_addr_q[out_id][0]] = 1'b1;
      void'(resv_addr_q[out_id].pop_front());
      void'(fill_msg_q[out_id].pop_front());
      accepts_done++;
    end
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    stop_on_error($sformatf("Timeout: test not finished after %0d cycles", TIMEOUT_CYCLES));
  end

  initial begin
    void'($urandom(86956));
    reservation_id_onehot_i = '0;
    reservation_ready_i = 1'b0;
    data_i = '0;
    in_valid_i = 1'b0;
    release_en_i = '0;
    out_ready_i = 1'b0;
    free_m = '1;
    stall_left = 0;
    accepts_done = 0;

    wait (rst_n == 1'b1);
    @(negedge clk);
    check_bit("reservation_valid_o", reservation_valid_o, 1'b1);
    check_addr("new_reserved_address_o", new_reserved_address_o, '0);
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("in_ready_o", in_ready_o, 1'b0);
    check_slots("address_released_onehot_o", address_released_onehot_o, '0);

    repeat (NUM_CYCLES) begin
      @(posedge clk);
      drive_inputs(1'b0);
      @(negedge clk);
      compare_and_update();
    end

    // Drain everything still reserved or waiting in the output register
    while (!model_empty() || out_valid_o) begin
      @(posedge clk);
      drive_inputs(1'b1);
      @(negedge clk);
      compare_and_update();
    end

    check_bit("reservation_valid_o", reservation_valid_o, 1'b1);
    check_addr("new_reserved_address_o", new_reserved_address_o, '0);
    if (accepts_done == 0) begin
      stop_on_error("No message passed through the bank during the run");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

/* wresp_bank.f */
+incdir+include
design/wresp_bank_pkg.sv
design/wresp_slot_alloc.sv
design/wresp_slot_store.sv
design/wresp_release_sel.sv
design/wresp_queue_ctrl.sv
design/wresp_bank_top.sv
testbench/wresp_clk_gen.sv
testbench/wresp_bank_chk.sv
testbench/wresp_bank_tb.sv

/* Makefile */
TOP = wresp_bank_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f wresp_bank.f \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
